//--- rtl/dcache_consts.svh
// Cache geometry constants, included by the package and by every RTL file that sizes a port or array
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Width of a load or store word and of a byte address
`define DC_DATA_WIDTH 32
`define DC_ADDR_WIDTH 16

// Cache and line size in bytes
`define DC_CACHE_SIZE 256
`define DC_LINE_SIZE 16

// Line and word sizes in the other unit
`define DC_LINE_WIDTH (`DC_LINE_SIZE * 8)
`define DC_DATA_SIZE (`DC_DATA_WIDTH / 8)

// Address split as tag, index and byte offset
`define DC_OFFSET_WIDTH $clog2(`DC_LINE_SIZE)
`define DC_INDEX_WIDTH $clog2(`DC_CACHE_SIZE / `DC_LINE_SIZE)
`define DC_TAG_WIDTH (`DC_ADDR_WIDTH - `DC_INDEX_WIDTH - `DC_OFFSET_WIDTH)

`endif

//--- rtl/dcache_pkg.sv
// Shared data cache types, referenced by scoped name from the stores, the hit stage and the top
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    // Operation carried by a request
    typedef enum logic [1:0] {
        op_load  = 2'd0,
        op_store = 2'd1,
        op_fill  = 2'd2
    } dcache_op_e;

    // One request entering the pipeline
    // The valid and dirty fields are the state the written line receives
    typedef struct packed {
        dcache_op_e                   op;
        logic [`DC_TAG_WIDTH-1:0]     tag;
        logic [`DC_INDEX_WIDTH-1:0]   index;
        logic [`DC_OFFSET_WIDTH-1:0]  offset;
        logic [`DC_DATA_SIZE-1:0]     byte_sel;
        logic [`DC_DATA_WIDTH-1:0]    data;
        logic [`DC_LINE_WIDTH-1:0]    fill_data;
        logic                         valid;
        logic                         dirty;
    } dcache_req_t;

    // State held per set in the tag store
    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        logic [`DC_TAG_WIDTH-1:0]     tag;
    } dcache_tag_t;

    // Write-back to both stores, also used as the forwarding source
    typedef struct packed {
        logic                         en;
        logic [`DC_INDEX_WIDTH-1:0]   index;
        logic [`DC_TAG_WIDTH-1:0]     tag;
        logic                         valid;
        logic                         dirty;
        logic [`DC_LINE_WIDTH-1:0]    data;
    } dcache_line_wr_t;

    // Dirty line displaced by a fill
    typedef struct packed {
        logic                         valid;
        logic [`DC_ADDR_WIDTH-1:0]    addr;
        logic [`DC_LINE_WIDTH-1:0]    data;
    } dcache_victim_t;

endpackage

`default_nettype wire

//--- rtl/dcache_tag_store.sv
// Valid, dirty and tag array of the data cache, first pipeline stage beside the data store
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tag_store (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    input  logic                        i_req_en,
    input  dcache_pkg::dcache_req_t     i_req,

    input  dcache_pkg::dcache_line_wr_t i_line_wr,

    output logic                        o_req_valid,
    output dcache_pkg::dcache_req_t     o_req,
    output dcache_pkg::dcache_tag_t     o_entry
);

    localparam int SET_COUNT = `DC_CACHE_SIZE / `DC_LINE_SIZE;

    logic [SET_COUNT-1:0]      valid_q;
    logic [SET_COUNT-1:0]      dirty_q;
    logic [`DC_TAG_WIDTH-1:0]  tag_q [SET_COUNT];

    logic                      req_valid_q;
    dcache_pkg::dcache_req_t   req_q;
    dcache_pkg::dcache_tag_t   entry_q;
    logic                      wr_same_index;

    // Valid bits are cleared by reset and then follow each line write
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
        end else if (i_line_wr.en) begin
            valid_q[i_line_wr.index] <= i_line_wr.valid;
        end
    end

    // Dirty bit and tag of the set named by the line write
    always_ff @(posedge i_clk) begin
        if (i_line_wr.en) begin
            dirty_q[i_line_wr.index] <= i_line_wr.dirty;
            tag_q[i_line_wr.index]   <= i_line_wr.tag;
        end
    end

    // A write landing on the same edge as the read returns the new entry
    assign wr_same_index = i_line_wr.en && (i_line_wr.index == i_req.index);

    always_ff @(posedge i_clk) begin
        if (i_req_en) begin
            req_q <= i_req;
            if (wr_same_index) begin
                entry_q.valid <= i_line_wr.valid;
                entry_q.dirty <= i_line_wr.dirty;
                entry_q.tag   <= i_line_wr.tag;
            end else begin
                entry_q.valid <= valid_q[i_req.index];
                entry_q.dirty <= dirty_q[i_req.index];
                entry_q.tag   <= tag_q[i_req.index];
            end
        end
    end

    // Marks that the registered request is live in the next stage
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= i_req_en;
        end
    end

    assign o_req_valid = req_valid_q;
    assign o_req       = req_q;
    assign o_entry     = entry_q;

    // A fill must never install a line that is dirty but not valid
    a_fill_state_consistent: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_req_en && (i_req.op == dcache_pkg::op_fill) && i_req.dirty) |-> i_req.valid
    );

endmodule

`default_nettype wire

//--- rtl/dcache_data_store.sv
// Line data array of the data cache, read in the first stage and written from the hit stage
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_data_store (
    input  logic                        i_clk,

    input  logic                        i_req_en,
    input  logic [`DC_INDEX_WIDTH-1:0]  i_index,

    input  dcache_pkg::dcache_line_wr_t i_line_wr,

    output logic [`DC_LINE_WIDTH-1:0]   o_line
);

    localparam int SET_COUNT = `DC_CACHE_SIZE / `DC_LINE_SIZE;

    logic [`DC_LINE_WIDTH-1:0] mem [SET_COUNT];
    logic [`DC_LINE_WIDTH-1:0] line_q;
    logic                      wr_same_index;

    always_ff @(posedge i_clk) begin
        if (i_line_wr.en) begin
            mem[i_line_wr.index] <= i_line_wr.data;
        end
    end

    // Read is write-first so it agrees with the tag store on a same-edge write
    assign wr_same_index = i_line_wr.en && (i_line_wr.index == i_index);

    always_ff @(posedge i_clk) begin
        if (i_req_en) begin
            if (wr_same_index) begin
                line_q <= i_line_wr.data;
            end else begin
                line_q <= mem[i_index];
            end
        end
    end

    assign o_line = line_q;

endmodule

`default_nettype wire

//--- rtl/dcache_dw.sv
// Second cache stage that checks for a hit, extracts load data and builds the line write and victim
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_dw (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    input  logic                        i_req_valid,
    input  dcache_pkg::dcache_req_t     i_req,
    input  dcache_pkg::dcache_tag_t     i_entry,
    input  logic [`DC_LINE_WIDTH-1:0]   i_line,

    input  dcache_pkg::dcache_line_wr_t i_fwd,

    output dcache_pkg::dcache_line_wr_t o_line_wr,
    output logic                        o_hit,
    output logic [`DC_DATA_WIDTH-1:0]   o_data,
    output dcache_pkg::dcache_victim_t  o_victim
);

    localparam int LINE_SIZE = `DC_LINE_SIZE;
    localparam int DATA_SIZE = `DC_DATA_SIZE;

    logic                        fwd_on_index;
    logic                        fwd_tag_match;
    logic [`DC_TAG_WIDTH-1:0]    cur_tag;
    logic                        cur_valid;
    logic                        cur_dirty;
    logic [`DC_LINE_WIDTH-1:0]   cur_line;
    logic [`DC_LINE_WIDTH-1:0]   victim_line;

    logic                        is_store;
    logic                        is_fill;
    logic                        hit;
    logic                        wr_en;
    logic                        victim_valid;
    logic [`DC_ADDR_WIDTH-1:0]   victim_addr;
    logic [`DC_DATA_WIDTH-1:0]   rd_word;
    logic [`DC_LINE_WIDTH-1:0]   wr_line;

    logic                        hit_q;
    logic                        wr_en_q;
    logic                        victim_valid_q;
    logic [`DC_DATA_WIDTH-1:0]   data_q;
    logic [`DC_INDEX_WIDTH-1:0]  wr_index_q;
    logic [`DC_TAG_WIDTH-1:0]    wr_tag_q;
    logic                        wr_valid_q;
    logic                        wr_dirty_q;
    logic [`DC_LINE_WIDTH-1:0]   wr_line_q;
    logic [`DC_ADDR_WIDTH-1:0]   victim_addr_q;
    logic [`DC_LINE_WIDTH-1:0]   victim_data_q;

    // The line being written back this cycle is newer than what the stores returned
    assign fwd_on_index  = i_fwd.en && (i_fwd.index == i_req.index);
    assign fwd_tag_match = fwd_on_index && (i_fwd.tag == i_req.tag);

    assign cur_tag   = fwd_on_index ? i_fwd.tag   : i_entry.tag;
    assign cur_valid = fwd_on_index ? i_fwd.valid : i_entry.valid;
    assign cur_dirty = fwd_on_index ? i_fwd.dirty : i_entry.dirty;

    // Load and merge only see the forwarded data when it is the same line
    assign cur_line    = fwd_tag_match ? i_fwd.data : i_line;
    assign victim_line = fwd_on_index  ? i_fwd.data : i_line;

    assign is_store = (i_req.op == dcache_pkg::op_store);
    assign is_fill  = (i_req.op == dcache_pkg::op_fill);

    assign hit = cur_valid && (cur_tag == i_req.tag);

    // Fills always write, stores only when the line is present
    assign wr_en        = i_req_valid && (is_fill || (is_store && hit));
    assign victim_valid = i_req_valid && is_fill && cur_valid && cur_dirty;
    assign victim_addr  = {cur_tag, i_req.index, `DC_OFFSET_WIDTH'(0)};

    // Pick the selected bytes at the offset; bytes past the end of the line read as zero
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < LINE_SIZE; i++) begin
            if (i_req.offset == `DC_OFFSET_WIDTH'(i)) begin
                for (int j = 0; (j < DATA_SIZE) && (i + j < LINE_SIZE); j++) begin
                    if (i_req.byte_sel[j]) begin
                        rd_word[j*8 +: 8] = cur_line[(i+j)*8 +: 8];
                    end
                end
            end
        end
    end

    // Store bytes are placed at the offset with the same end-of-line limit
    always_comb begin
        wr_line = cur_line;
        for (int i = 0; i < LINE_SIZE; i++) begin
            if (i_req.offset == `DC_OFFSET_WIDTH'(i)) begin
                for (int j = 0; (j < DATA_SIZE) && (i + j < LINE_SIZE); j++) begin
                    if (i_req.byte_sel[j]) begin
                        wr_line[(i+j)*8 +: 8] = i_req.data[j*8 +: 8];
                    end
                end
            end
        end

        // A fill replaces the whole line
        if (is_fill) begin
            wr_line = i_req.fill_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hit_q          <= 1'b0;
            wr_en_q        <= 1'b0;
            victim_valid_q <= 1'b0;
        end else begin
            hit_q          <= i_req_valid && hit;
            wr_en_q        <= wr_en;
            victim_valid_q <= victim_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        data_q        <= rd_word;
        wr_index_q    <= i_req.index;
        wr_tag_q      <= i_req.tag;
        wr_valid_q    <= i_req.valid;
        wr_dirty_q    <= i_req.dirty;
        wr_line_q     <= wr_line;
        victim_addr_q <= victim_addr;
        victim_data_q <= victim_line;
    end

    always_comb begin
        o_line_wr.en    = wr_en_q;
        o_line_wr.index = wr_index_q;
        o_line_wr.tag   = wr_tag_q;
        o_line_wr.valid = wr_valid_q;
        o_line_wr.dirty = wr_dirty_q;
        o_line_wr.data  = wr_line_q;
        o_victim.valid  = victim_valid_q;
        o_victim.addr   = victim_addr_q;
        o_victim.data   = victim_data_q;
    end

    assign o_hit  = hit_q;
    assign o_data = data_q;

    // A victim is only reported together with the fill that displaces it
    a_victim_with_write: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_victim.valid |-> o_line_wr.en
    );

    // No write-back appears without a request having been in this stage
    a_write_needs_request: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_req_valid |=> !o_line_wr.en
    );

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
// Data cache pipeline top that joins both stores to the hit stage and feeds the write-back around
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    input  logic                        i_req_en,
    input  dcache_pkg::dcache_req_t     i_req,

    output logic                        o_hit,
    output logic [`DC_DATA_WIDTH-1:0]   o_data,
    output dcache_pkg::dcache_line_wr_t o_line_wr,
    output dcache_pkg::dcache_victim_t  o_victim
);

    logic                        req_valid;
    dcache_pkg::dcache_req_t     req;
    dcache_pkg::dcache_tag_t     entry;
    logic [`DC_LINE_WIDTH-1:0]   line;
    dcache_pkg::dcache_line_wr_t line_wr;

    dcache_tag_store u_tag_store (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req_en    (i_req_en),
        .i_req       (i_req),
        .i_line_wr   (line_wr),
        .o_req_valid (req_valid),
        .o_req       (req),
        .o_entry     (entry)
    );

    dcache_data_store u_data_store (
        .i_clk     (i_clk),
        .i_req_en  (i_req_en),
        .i_index   (i_req.index),
        .i_line_wr (line_wr),
        .o_line    (line)
    );

    // The stage's own write-back also serves as its forwarding source
    dcache_dw u_dw (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (req_valid),
        .i_req       (req),
        .i_entry     (entry),
        .i_line      (line),
        .i_fwd       (line_wr),
        .o_line_wr   (line_wr),
        .o_hit       (o_hit),
        .o_data      (o_data),
        .o_victim    (o_victim)
    );

    assign o_line_wr = line_wr;

endmodule

`default_nettype wire

//--- verif/dcache_tb.sv
// Self-checking testbench for the data cache pipeline, run as the top module through all.f
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb;

    localparam int SET_COUNT     = `DC_CACHE_SIZE / `DC_LINE_SIZE;
    localparam int TAG_W         = `DC_TAG_WIDTH;
    localparam int INDEX_W       = `DC_INDEX_WIDTH;
    localparam int OFF_W         = `DC_OFFSET_WIDTH;
    localparam int DRAIN_TIMEOUT = 20;
    localparam int RANDOM_COUNT  = 300;

    // Expected outcome of one request, checked two cycles after its strobe
    typedef struct packed {
        logic                          valid;
        logic                          hit;
        logic                          check_data;
        logic [`DC_DATA_WIDTH-1:0]     data;
        dcache_pkg::dcache_line_wr_t   line_wr;
        dcache_pkg::dcache_victim_t    victim;
    } exp_t;

    logic                          clk;
    logic                          rst_n;
    logic                          req_en;
    dcache_pkg::dcache_req_t       req;
    logic                          hit;
    logic [`DC_DATA_WIDTH-1:0]     rd_data;
    dcache_pkg::dcache_line_wr_t   line_wr;
    dcache_pkg::dcache_victim_t    victim;

    // Two-entry queue of expected results that moves along with the pipeline
    exp_t                          exp_in;
    exp_t                          exp_s1;
    exp_t                          exp_s2;

    logic                          model_valid [SET_COUNT];
    logic                          model_dirty [SET_COUNT];
    logic [`DC_TAG_WIDTH-1:0]      model_tag   [SET_COUNT];
    logic [`DC_LINE_WIDTH-1:0]     model_line  [SET_COUNT];

    logic [15:0]                   lfsr;
    int                            mismatch_count = 0;
    int                            timeout_count = 0;

    dcache_top dut (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_req_en  (req_en),
        .i_req     (req),
        .o_hit     (hit),
        .o_data    (rd_data),
        .o_line_wr (line_wr),
        .o_victim  (victim)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_s1 <= '0;
            exp_s2 <= '0;
        end else begin
            exp_s1 <= exp_in;
            exp_s2 <= exp_s1;
        end
    end

    task automatic report_mismatch(input string name, input logic [159:0] exp_v,
                                   input logic [159:0] act_v);
        mismatch_count++;
        $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp_v, act_v);
    endtask

    a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> !line_wr.en && !victim.valid)
        else report_mismatch("o_line_wr.en/o_victim.valid", 160'(0),
                             160'({$sampled(line_wr.en), $sampled(victim.valid)}));

    a_hit: assert property (@(posedge clk) disable iff (!rst_n)
        exp_s2.valid |-> hit == exp_s2.hit)
        else report_mismatch("o_hit", 160'($sampled(exp_s2.hit)), 160'($sampled(hit)));

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        exp_s2.check_data |-> rd_data == exp_s2.data)
        else report_mismatch("o_data", 160'($sampled(exp_s2.data)), 160'($sampled(rd_data)));

    a_wr_en: assert property (@(posedge clk) disable iff (!rst_n)
        line_wr.en == exp_s2.line_wr.en)
        else report_mismatch("o_line_wr.en", 160'($sampled(exp_s2.line_wr.en)),
                             160'($sampled(line_wr.en)));

    a_wr_line: assert property (@(posedge clk) disable iff (!rst_n)
        exp_s2.line_wr.en |-> line_wr == exp_s2.line_wr)
        else report_mismatch("o_line_wr", 160'($sampled(exp_s2.line_wr)),
                             160'($sampled(line_wr)));

    a_victim_valid: assert property (@(posedge clk) disable iff (!rst_n)
        victim.valid == exp_s2.victim.valid)
        else report_mismatch("o_victim.valid", 160'($sampled(exp_s2.victim.valid)),
                             160'($sampled(victim.valid)));

    a_victim_line: assert property (@(posedge clk) disable iff (!rst_n)
        exp_s2.victim.valid |-> victim == exp_s2.victim)
        else report_mismatch("o_victim", 160'($sampled(exp_s2.victim)),
                             160'($sampled(victim)));

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [`DC_LINE_WIDTH-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic build_req(input dcache_pkg::dcache_op_e op, input int tag, input int index,
                             input logic dirty, output dcache_pkg::dcache_req_t r);
        logic [`DC_LINE_WIDTH-1:0] bits;
        r = '0;
        r.op = op;
        r.tag = TAG_W'(tag);
        r.index = INDEX_W'(index);
        take_bits(OFF_W, bits);
        r.offset = bits[OFF_W-1:0];
        take_bits(`DC_DATA_SIZE, bits);
        r.byte_sel = bits[`DC_DATA_SIZE-1:0];
        take_bits(`DC_DATA_WIDTH, bits);
        r.data = bits[`DC_DATA_WIDTH-1:0];
        take_bits(`DC_LINE_WIDTH, bits);
        r.fill_data = bits;
        r.valid = (op != dcache_pkg::op_load);
        r.dirty = (op == dcache_pkg::op_store) || ((op == dcache_pkg::op_fill) && dirty);
    endtask

    // The model runs in program order, which is what forwarding makes the pipeline look like
    task automatic predict(input dcache_pkg::dcache_req_t r, output exp_t e);
        int                         p;
        logic                       line_hit;
        logic [`DC_LINE_WIDTH-1:0]  old_line;
        logic [`DC_LINE_WIDTH-1:0]  new_line;
        logic [`DC_DATA_WIDTH-1:0]  word;
        old_line = model_line[r.index];
        line_hit = model_valid[r.index] && (model_tag[r.index] == r.tag);
        new_line = old_line;
        word = '0;
        for (int j = 0; j < `DC_DATA_SIZE; j++) begin
            p = int'(r.offset) + j;
            // Bytes that would fall past the end of the line are dropped
            if (r.byte_sel[j] && (p < `DC_LINE_SIZE)) begin
                word[j*8 +: 8] = old_line[p*8 +: 8];
                new_line[p*8 +: 8] = r.data[j*8 +: 8];
            end
        end
        if (r.op == dcache_pkg::op_fill) begin
            new_line = r.fill_data;
        end
        e = '0;
        e.valid = 1'b1;
        e.hit = line_hit;
        e.check_data = (r.op == dcache_pkg::op_load) && line_hit;
        e.data = word;
        e.line_wr.en = (r.op == dcache_pkg::op_fill) || ((r.op == dcache_pkg::op_store) && line_hit);
        e.line_wr.index = r.index;
        e.line_wr.tag = r.tag;
        e.line_wr.valid = r.valid;
        e.line_wr.dirty = r.dirty;
        e.line_wr.data = new_line;
        e.victim.valid = (r.op == dcache_pkg::op_fill) && model_valid[r.index]
                         && model_dirty[r.index];
        e.victim.addr = {model_tag[r.index], r.index, {OFF_W{1'b0}}};
        e.victim.data = old_line;
        if (e.line_wr.en) begin
            model_valid[r.index] = r.valid;
            model_dirty[r.index] = r.dirty;
            model_tag[r.index] = r.tag;
            model_line[r.index] = new_line;
        end
    endtask

    task automatic drive_req(input dcache_pkg::dcache_req_t r);
        exp_t e;
        @(negedge clk);
        predict(r, e);
        req = r;
        req_en = 1'b1;
        exp_in = e;
    endtask

    task automatic drive_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            req_en = 1'b0;
            exp_in = '0;
        end
    endtask

    initial begin
        dcache_pkg::dcache_req_t    r;
        dcache_pkg::dcache_req_t    st;
        dcache_pkg::dcache_op_e     op;
        logic [`DC_LINE_WIDTH-1:0]  bits;
        int                         cycles;

        rst_n = 1'b0;
        req_en = 1'b0;
        req = '0;
        exp_in = '0;
        lfsr = 16'd54;
        for (int i = 0; i < SET_COUNT; i++) begin
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
            model_tag[i] = '0;
            model_line[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Nothing is cached yet so each of these must miss
        for (int i = 0; i < SET_COUNT; i++) begin
            build_req(dcache_pkg::op_load, i, i, 1'b0, r);
            drive_req(r);
        end

        // Fill, then load at random offsets and at the end of the line
        build_req(dcache_pkg::op_fill, 'h5a, 3, 1'b0, r);
        drive_req(r);
        drive_idle(2);
        for (int i = 0; i < 12; i++) begin
            build_req(dcache_pkg::op_load, 'h5a, 3, 1'b0, r);
            drive_req(r);
        end
        for (int i = 12; i < `DC_LINE_SIZE; i++) begin
            build_req(dcache_pkg::op_load, 'h5a, 3, 1'b0, r);
            r.offset = OFF_W'(i);
            r.byte_sel = '1;
            drive_req(r);
        end

        // Store hit, a load of the merged line, then a store miss
        build_req(dcache_pkg::op_store, 'h5a, 3, 1'b1, r);
        drive_req(r);
        drive_idle(2);
        build_req(dcache_pkg::op_load, 'h5a, 3, 1'b0, r);
        drive_req(r);
        build_req(dcache_pkg::op_store, 'ha5, 3, 1'b1, r);
        drive_req(r);
        drive_idle(3);

        // Dirty victim, clean victim and a fill into an empty set
        build_req(dcache_pkg::op_fill, 'h11, 3, 1'b0, r);
        drive_req(r);
        drive_idle(3);
        build_req(dcache_pkg::op_fill, 'h22, 3, 1'b0, r);
        drive_req(r);
        build_req(dcache_pkg::op_fill, 'h33, 9, 1'b1, r);
        drive_req(r);
        drive_idle(3);

        // Back-to-back requests to one line rely on forwarding
        build_req(dcache_pkg::op_fill, 'h30, 5, 1'b0, r);
        drive_req(r);
        drive_idle(3);
        build_req(dcache_pkg::op_store, 'h30, 5, 1'b1, st);
        drive_req(st);
        build_req(dcache_pkg::op_load, 'h30, 5, 1'b0, r);
        r.offset = st.offset;
        r.byte_sel = '1;
        drive_req(r);
        build_req(dcache_pkg::op_store, 'h30, 5, 1'b1, r);
        r.offset = st.offset;
        drive_req(r);
        drive_idle(3);
        build_req(dcache_pkg::op_fill, 'h40, 6, 1'b1, r);
        drive_req(r);
        build_req(dcache_pkg::op_fill, 'h41, 6, 1'b0, r);
        drive_req(r);
        drive_idle(3);

        // Few tags and sets so that hits, victims and forwarding happen often
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            take_bits(8, bits);
            if (bits[1:0] == 2'd1) begin
                op = dcache_pkg::op_store;
            end else if (bits[1:0] == 2'd2) begin
                op = dcache_pkg::op_fill;
            end else begin
                op = dcache_pkg::op_load;
            end
            if (bits[7]) begin
                drive_idle(1);
            end
            build_req(op, int'(bits[3:2]), int'(bits[5:4]), bits[6], r);
            drive_req(r);
        end
        drive_idle(1);

        cycles = 0;
        while ((exp_in.valid || exp_s1.valid || exp_s2.valid) && (cycles < DRAIN_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_in.valid || exp_s1.valid || exp_s2.valid) begin
            timeout_count++;
            $display("Timeout: expected results still pending after %0d cycles", cycles);
        end

        $display("Errors: mismatches=%0d timeouts=%0d", mismatch_count, timeout_count);
        if ((mismatch_count == 0) && (timeout_count == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_dw.sv
rtl/dcache_top.sv
verif/dcache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dcache_tb -f all.f -o dcache_sim

out="$(./obj_dir/dcache_sim)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Simulation finished: PASS'; then
    exit 0
fi
exit 1
